/* edge_io_pkg.sv */
`default_nettype none

package edge_io_pkg;

  //////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////

  // Data RAM covers byte addresses 0x0000_0000 to 0x0000_0FFF
  localparam int unsigned RAM_WORDS = 1024;
  localparam int unsigned RAM_AW    = 10;

  // Memory-mapped I/O registers live at the top of the address space
  localparam logic [31:0] LED_ADDR       = 32'hFFFF_0000;
  localparam logic [31:0] UART_DATA_ADDR = 32'hFFFF_0004;
  localparam logic [31:0] UART_STAT_ADDR = 32'hFFFF_0008;

  //////////////////////////////////////////////////
  // UART transmit path
  //////////////////////////////////////////////////

  // Depth of the byte FIFO and its pointer index width
  localparam int unsigned FIFO_DEPTH = 16;
  localparam int unsigned FIFO_AW    = 4;

  // Clock cycles per serial bit, kept small so that simulation stays short
  localparam int unsigned CLKS_PER_BIT = 16;

  //////////////////////////////////////////////////
  // Processor bus
  //////////////////////////////////////////////////

  // Width of a store; the code 3 is never issued by the core
  typedef enum logic [1:0] {
    SIZE_WORD = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_BYTE = 2'd2
  } ref_size_e;

  // One request from the processor data port
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
    ref_size_e   size;
  } mem_req_t;

endpackage

`default_nettype wire

/* data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram
  import edge_io_pkg::*;
(
  input  logic              CLK_50MHz,
  input  logic              we,
  input  logic [3:0]        byte_en,
  input  logic [RAM_AW-1:0] word_addr,
  input  logic [31:0]       wdata,
  output logic [31:0]       rdata
);

  // Word-organized storage standing in for a block RAM
  logic [31:0] mem [RAM_WORDS];

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  // Each byte lane is written only when its own enable is set
  // The data already arrives replicated into the right lanes
  always_ff @(posedge CLK_50MHz) begin
    if (we) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (byte_en[lane]) begin
          mem[word_addr][lane*8 +: 8] <= wdata[lane*8 +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  // Asynchronous read, so a store shows up on rdata one cycle later
  assign rdata = mem[word_addr];

endmodule

`default_nettype wire

/* memory_system.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_system
  import edge_io_pkg::*;
(
  input  logic        CLK_50MHz,
  input  logic        rst_n,
  input  mem_req_t    req,
  output logic [31:0] rd,
  output logic        stall,
  output logic [7:0]  led,
  output logic        push,
  output logic [7:0]  push_data,
  input  logic        fifo_full,
  input  logic        fifo_empty,
  input  logic        tx_busy
);

  logic        ram_sel;
  logic        led_sel;
  logic        uart_data_sel;
  logic        uart_stat_sel;
  logic        store_ok;
  logic [3:0]  byte_en;
  logic [31:0] lane_data;
  logic [31:0] ram_rdata;
  logic [31:0] status;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  // RAM answers whenever all bits above the word index are zero
  assign ram_sel       = (req.addr[31:RAM_AW+2] == '0);
  assign led_sel       = (req.addr == LED_ADDR);
  assign uart_data_sel = (req.addr == UART_DATA_ADDR);
  assign uart_stat_sel = (req.addr == UART_STAT_ADDR);

  // Only a store to the UART data register can back up, and only on a full FIFO
  assign stall    = req.we && uart_data_sel && fifo_full;
  assign store_ok = req.we && !stall;

  //////////////////////////////////////////////////
  // Store lane steering
  //////////////////////////////////////////////////

  // Little-endian lanes; halfwords pick the lane pair with addr bit 1
  always_comb begin
    byte_en   = 4'b0000;
    lane_data = req.wdata;
    case (req.size)
      SIZE_WORD: begin
        byte_en   = 4'b1111;
        lane_data = req.wdata;
      end
      SIZE_HALF: begin
        byte_en   = req.addr[1] ? 4'b1100 : 4'b0011;
        lane_data = {2{req.wdata[15:0]}};
      end
      SIZE_BYTE: begin
        byte_en   = 4'b0001 << req.addr[1:0];
        lane_data = {4{req.wdata[7:0]}};
      end
      default: byte_en = 4'b0000;
    endcase
  end

  data_ram data_ram_i (
    .CLK_50MHz (CLK_50MHz),
    .we        (store_ok && ram_sel),
    .byte_en   (byte_en),
    .word_addr (req.addr[RAM_AW+1:2]),
    .wdata     (lane_data),
    .rdata     (ram_rdata)
  );

  // LED register keeps the low byte of the last store to its address
  always_ff @(posedge CLK_50MHz or negedge rst_n) begin
    if (!rst_n) begin
      led <= 8'h00;
    end else if (store_ok && led_sel) begin
      led <= req.wdata[7:0];
    end
  end

  // A UART data store pushes one byte straight into the FIFO
  assign push      = store_ok && uart_data_sel;
  assign push_data = req.wdata[7:0];

  //////////////////////////////////////////////////
  // Read data
  //////////////////////////////////////////////////

  // Bit 0 says there is room and bit 1 says the line has fully drained
  assign status = {30'd0, (!tx_busy && fifo_empty), !fifo_full};

  always_comb begin
    rd = 32'd0;
    if (ram_sel) begin
      rd = ram_rdata;
    end else if (led_sel) begin
      rd = {24'd0, led};
    end else if (uart_stat_sel) begin
      rd = status;
    end
  end

  // The core never issues the reserved size code on a store
  a_size_legal: assert property (@(posedge CLK_50MHz) disable iff (!rst_n)
    req.we |-> (req.size inside {SIZE_WORD, SIZE_HALF, SIZE_BYTE}));

endmodule

`default_nettype wire

/* uart_tx_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_fifo
  import edge_io_pkg::*;
(
  input  logic       CLK_50MHz,
  input  logic       rst_n,
  input  logic       push,
  input  logic [7:0] push_data,
  input  logic       pop,
  output logic [7:0] pop_data,
  output logic       full,
  output logic       empty
);

  // Byte storage indexed by the low pointer bits
  logic [7:0]       mem [FIFO_DEPTH];

  // One extra pointer bit tells a wrapped write pointer from an equal one
  logic [FIFO_AW:0] wr_ptr;
  logic [FIFO_AW:0] rd_ptr;

  //////////////////////////////////////////////////
  // Pointers and storage
  //////////////////////////////////////////////////

  always_ff @(posedge CLK_50MHz or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK_50MHz) begin
    if (push) begin
      mem[wr_ptr[FIFO_AW-1:0]] <= push_data;
    end
  end

  //////////////////////////////////////////////////
  // Status and head byte
  //////////////////////////////////////////////////

  // Same index with opposite wrap bits means the write side lapped the read side
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                 (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

  assign pop_data = mem[rd_ptr[FIFO_AW-1:0]];

  // The transmitter only pops a byte that is really there
  a_no_pop_empty: assert property (@(posedge CLK_50MHz) disable iff (!rst_n)
    empty |-> !pop);

  // The decoder stall must hold back any push into a full FIFO
  a_no_push_full: assert property (@(posedge CLK_50MHz) disable iff (!rst_n)
    full |-> !push);

endmodule

`default_nettype wire

/* uart_tx_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_ctrl
  import edge_io_pkg::*;
(
  input  logic       CLK_50MHz,
  input  logic       rst_n,
  input  logic       empty,
  input  logic [7:0] pop_data,
  output logic       pop,
  output logic       busy,
  output logic       uart_txd
);

  localparam int unsigned BAUD_W = $clog2(CLKS_PER_BIT);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } tx_state_e;

  tx_state_e         state;
  logic [BAUD_W-1:0] baud_cnt;
  logic [2:0]        bit_idx;
  logic [9:0]        frame;
  logic              bit_done;

  //////////////////////////////////////////////////
  // Pop control
  //////////////////////////////////////////////////

  // A bit period ends when the baud counter reaches its last count
  assign bit_done = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

  // Take a new byte when idle, or right as the stop bit ends
  assign pop  = !empty && ((state == ST_IDLE) || ((state == ST_STOP) && bit_done));
  assign busy = (state != ST_IDLE);

  // The line always shows bit 0 of the frame register
  assign uart_txd = frame[0];

  //////////////////////////////////////////////////
  // Frame FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK_50MHz or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      frame    <= '1;
    end else if (pop) begin
      // Stop bit, data LSB first, start bit at the bottom
      state    <= ST_START;
      baud_cnt <= '0;
      bit_idx  <= '0;
      frame    <= {1'b1, pop_data, 1'b0};
    end else if (state != ST_IDLE) begin
      baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
      if (bit_done) begin
        // Shift in ones so the line rests high once the frame is out
        frame <= {1'b1, frame[9:1]};
        case (state)
          ST_START: state <= ST_DATA;
          ST_DATA: begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= ST_STOP;
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  // Every frame bit gets shifted out, so the line is back high by idle
  a_idle_high: assert property (@(posedge CLK_50MHz) disable iff (!rst_n)
    (state == ST_IDLE) |-> uart_txd);

endmodule

`default_nettype wire

/* edge_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_io_top
  import edge_io_pkg::*;
(
  input  logic        CLK_50MHz,
  input  logic        rst_n,
  input  mem_req_t    req,
  output logic [31:0] rd,
  output logic        stall,
  output logic [7:0]  led,
  output logic        uart_txd
);

  // Decoder to FIFO
  logic       push;
  logic [7:0] push_data;
  logic       fifo_full;
  logic       fifo_empty;

  // FIFO to transmitter, busy goes back for the status word
  logic       pop;
  logic [7:0] pop_data;
  logic       tx_busy;

  memory_system memory_system_i (
    .CLK_50MHz  (CLK_50MHz),
    .rst_n      (rst_n),
    .req        (req),
    .rd         (rd),
    .stall      (stall),
    .led        (led),
    .push       (push),
    .push_data  (push_data),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty),
    .tx_busy    (tx_busy)
  );

  uart_tx_fifo uart_tx_fifo_i (
    .CLK_50MHz (CLK_50MHz),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .full      (fifo_full),
    .empty     (fifo_empty)
  );

  uart_tx_ctrl uart_tx_ctrl_i (
    .CLK_50MHz (CLK_50MHz),
    .rst_n     (rst_n),
    .empty     (fifo_empty),
    .pop_data  (pop_data),
    .pop       (pop),
    .busy      (tx_busy),
    .uart_txd  (uart_txd)
  );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic CLK_50MHz,
  output logic rst_n
);

  // 50 MHz board clock, 20 ns period
  initial begin
    CLK_50MHz = 1'b0;
    forever #10 CLK_50MHz = ~CLK_50MHz;
  end

  // Reset is held for 16 cycles and released just after an edge
  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge CLK_50MHz);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tb_edge_io.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_edge_io
  import edge_io_pkg::*;
();

  localparam int STREAM_BYTES   = 12;
  localparam int BURST_BYTES    = 40;
  localparam int DRAIN_POLLS    = int'(2 * CLKS_PER_BIT);
  localparam int TIMEOUT_CYCLES = (STREAM_BYTES + BURST_BYTES) * 10 * int'(CLKS_PER_BIT) + 2000;

  logic        CLK_50MHz;
  logic        rst_n;
  mem_req_t    req;
  logic [31:0] rd;
  logic        stall;
  logic [7:0]  led;
  logic        uart_txd;

  // Reference state for the RAM and a mask of the lanes that hold known data
  logic [31:0] ram_model [RAM_WORDS];
  logic [31:0] known [RAM_WORDS];
  logic [7:0]  expect_q [$];
  logic [31:0] rng          = 32'h2259e8ca;
  int          sent_count   = 0;
  int          rx_count     = 0;
  int          errors       = 0;
  int          tests_failed = 0;
  int          cycles       = 0;

  tb_clock_gen tb_clock_gen_i (
    .CLK_50MHz (CLK_50MHz),
    .rst_n     (rst_n)
  );

  edge_io_top edge_io_top_i (
    .CLK_50MHz (CLK_50MHz),
    .rst_n     (rst_n),
    .req       (req),
    .rd        (rd),
    .stall     (stall),
    .led       (led),
    .uart_txd  (uart_txd)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic ref_size_e pick_size(input logic [31:0] r);
    ref_size_e s;
    case (r % 3)
      0: s = SIZE_WORD;
      1: s = SIZE_HALF;
      default: s = SIZE_BYTE;
    endcase
    return s;
  endfunction

  // Little-endian lanes where halfwords pick their pair with offset bit 1
  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [1:0] offs,
                                              input logic [31:0] data, input ref_size_e size);
    logic [31:0] word;
    word = old;
    case (size)
      SIZE_WORD: word = data;
      SIZE_HALF: begin
        if (offs[1]) begin
          word[31:16] = data[15:0];
        end else begin
          word[15:0] = data[15:0];
        end
      end
      default: word[{offs, 3'b000} +: 8] = data[7:0];
    endcase
    return word;
  endfunction

  // Every bus task starts and ends 1 ns after a rising edge
  task automatic idle_cycles(input logic [5:0] n);
    repeat (n) begin
      @(posedge CLK_50MHz);
      #1;
    end
  endtask

  // The request stays put while stall is high and the store lands on the edge after it drops
  task automatic store(input logic [31:0] addr, input logic [31:0] data,
                       input ref_size_e size, output logic stalled);
    req.addr  = addr;
    req.wdata = data;
    req.we    = 1'b1;
    req.size  = size;
    stalled   = 1'b0;
    @(negedge CLK_50MHz);
    while (stall) begin
      stalled = 1'b1;
      @(negedge CLK_50MHz);
    end
    @(posedge CLK_50MHz);
    #1;
    req.we = 1'b0;
  endtask

  task automatic load(input logic [31:0] addr, output logic [31:0] data);
    req.addr = addr;
    req.we   = 1'b0;
    @(negedge CLK_50MHz);
    data = rd;
    @(posedge CLK_50MHz);
    #1;
  endtask

  // Returns once every stored byte has come out of the line
  task automatic wait_line_idle();
    wait (rx_count == sent_count);
    @(posedge CLK_50MHz);
    #1;
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - errs_before);
      tests_failed++;
    end
  endtask

  //////////////////////////////////////////////////
  // Serial line monitor
  //////////////////////////////////////////////////

  // Samples each bit in its middle, starting half a bit after the start edge
  initial begin : line_monitor
    logic [7:0] rx_byte;
    logic [7:0] want;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge uart_txd);
      repeat (CLKS_PER_BIT / 2) @(negedge CLK_50MHz);
      if (uart_txd !== 1'b0) begin
        $display("framing fault: start bit was not low at mid-bit");
        errors++;
      end
      for (int b = 0; b < 8; b++) begin
        repeat (CLKS_PER_BIT) @(negedge CLK_50MHz);
        rx_byte = {uart_txd, rx_byte[7:1]};
      end
      repeat (CLKS_PER_BIT) @(negedge CLK_50MHz);
      if (uart_txd !== 1'b1) begin
        $display("framing fault: stop bit was not high at mid-bit");
        errors++;
      end
      if (expect_q.size() == 0) begin
        $display("line carried byte %h that was never stored", rx_byte);
        errors++;
      end else begin
        want = expect_q.pop_front();
        if (rx_byte !== want) begin
          $display("ERROR: uart_txd byte expected %h got %h", want, rx_byte);
          errors++;
        end
      end
      rx_count++;
    end
  end

  // The limit covers every frame back to back plus the plain bus traffic
  initial begin : watchdog
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge CLK_50MHz);
      cycles++;
    end
    $display("timeout after %0d cycles, the bus or the serial line stopped making progress",
             cycles);
    $display("TEST FAIL");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : main
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] word;
    logic [31:0] mask;
    logic [31:0] stat;
    logic [9:0]  idx;
    ref_size_e   size;
    logic        stalled;
    logic        stall_seen;
    int          errs_before;
    int          polls;

    req = '0;
    for (int i = 0; i < RAM_WORDS; i++) begin
      ram_model[i] = 32'd0;
      known[i]     = 32'd0;
    end
    wait (rst_n === 1'b1);
    @(posedge CLK_50MHz);
    #1;

    // Idle line, dark LEDs, no stall
    errs_before = errors;
    @(negedge CLK_50MHz);
    if (uart_txd !== 1'b1) begin
      $display("ERROR: uart_txd expected %h got %h", 1'b1, uart_txd);
      errors++;
    end
    if (led !== 8'h00) begin
      $display("ERROR: led expected %h got %h", 8'h00, led);
      errors++;
    end
    if (stall !== 1'b0) begin
      $display("ERROR: stall expected %h got %h", 1'b0, stall);
      errors++;
    end
    @(posedge CLK_50MHz);
    #1;
    report_test("reset state", errs_before);

    // Random sized stores, each read back right away
    errs_before = errors;
    for (int n = 0; n < 200; n++) begin
      r    = next_rand();
      size = pick_size(r);
      addr = {20'd0, r[19:8]};
      if (size == SIZE_WORD) begin
        addr[1:0] = 2'b00;
      end else if (size == SIZE_HALF) begin
        addr[0] = 1'b0;
      end
      data = next_rand();
      store(addr, data, size, stalled);
      idx            = addr[11:2];
      ram_model[idx] = merge_lanes(ram_model[idx], addr[1:0], data, size);
      known[idx]     = merge_lanes(known[idx], addr[1:0], 32'hFFFF_FFFF, size);
      load(addr, word);
      mask = known[idx];
      if ((word & mask) !== (ram_model[idx] & mask)) begin
        $display("ERROR: rd at %h expected %h got %h", addr, ram_model[idx] & mask, word & mask);
        errors++;
      end
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
      if (known[i] != 32'd0) begin
        load({20'd0, i[9:0], 2'b00}, word);
        if ((word & known[i]) !== (ram_model[i] & known[i])) begin
          $display("ERROR: rd at %h expected %h got %h", {20'd0, i[9:0], 2'b00},
                   ram_model[i] & known[i], word & known[i]);
          errors++;
        end
      end
    end
    report_test("ram stores", errs_before);

    // LED register keeps only the low byte
    errs_before = errors;
    for (int n = 0; n < 20; n++) begin
      data = next_rand();
      store(LED_ADDR, data, SIZE_WORD, stalled);
      load(LED_ADDR, word);
      if (led !== data[7:0]) begin
        $display("ERROR: led expected %h got %h", data[7:0], led);
        errors++;
      end
      if (word !== {24'd0, data[7:0]}) begin
        $display("ERROR: rd at %h expected %h got %h", LED_ADDR, {24'd0, data[7:0]}, word);
        errors++;
      end
    end
    addr = 32'h1000_0000 | (next_rand() & 32'h0FFF_FFFC);
    load(addr, word);
    if (word !== 32'd0) begin
      $display("ERROR: rd at %h expected %h got %h", addr, 32'd0, word);
      errors++;
    end
    report_test("led register", errs_before);

    // Bytes go out with idle gaps and their upper data bits are noise that must be dropped
    errs_before = errors;
    for (int n = 0; n < STREAM_BYTES; n++) begin
      r = next_rand();
      idle_cycles(r[13:8]);
      store(UART_DATA_ADDR, r, SIZE_BYTE, stalled);
      expect_q.push_back(r[7:0]);
      sent_count++;
    end
    wait_line_idle();
    report_test("uart stream", errs_before);

    // A status read sits just before each store, and since no push happens in between
    // the FIFO can only have drained, so a stall implies that read said full
    errs_before = errors;
    stall_seen  = 1'b0;
    for (int n = 0; n < BURST_BYTES; n++) begin
      load(UART_STAT_ADDR, stat);
      data = next_rand();
      store(UART_DATA_ADDR, data, SIZE_BYTE, stalled);
      if (stalled && (stat[0] !== 1'b0)) begin
        $display("ERROR: rd[0] at %h before a stalled store expected %h got %h",
                 UART_STAT_ADDR, 1'b0, stat[0]);
        errors++;
      end
      stall_seen = stall_seen | stalled;
      expect_q.push_back(data[7:0]);
      sent_count++;
    end
    if (!stall_seen) begin
      $display("stall never went high while the FIFO was being overrun");
      errors++;
    end
    wait_line_idle();
    report_test("back-pressure", errs_before);

    // The last stop bit was just sampled and the transmitter must settle soon after
    errs_before = errors;
    polls       = 0;
    stat        = 32'd0;
    while ((stat[1] !== 1'b1) && (polls < DRAIN_POLLS)) begin
      load(UART_STAT_ADDR, stat);
      polls++;
    end
    if (stat[1] !== 1'b1) begin
      $display("status never showed an idle line within %0d cycles", DRAIN_POLLS);
      errors++;
    end else if (stat[0] !== 1'b1) begin
      $display("ERROR: rd[0] at %h expected %h got %h", UART_STAT_ADDR, 1'b1, stat[0]);
      errors++;
    end
    report_test("drain status", errs_before);

    $display("tests run: 6, tests failed: %0d, errors: %0d", tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
edge_io_pkg.sv
data_ram.sv
memory_system.sv
uart_tx_fifo.sv
uart_tx_ctrl.sv
edge_io_top.sv
tb_clock_gen.sv
tb_edge_io.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_edge_io
RTL_TOP   ?= edge_io_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# The run passes only if the log holds the pass line
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
